//--- src/frameTrig_config.svh
// build-time constants; the pattern length must stay below 8 so beatIndex_t can hold it
`ifndef FRAME_TRIG_CONFIG_SVH
`define FRAME_TRIG_CONFIG_SVH

// number of beats compared at the start of every frame
`define FT_PATTERN_WORDS 5

// cycles the trigger stays high after a match, must be at least 1
`define FT_HOLD_CYCLES 10

// bytes per beat, also the strobe width
`define FT_BEAT_BYTES 4

// derived widths
`define FT_BEAT_BITS (`FT_BEAT_BYTES * 8)

// whole compare string, word 0 in the lowest bits
`define FT_PATTERN_BITS (`FT_PATTERN_WORDS * `FT_BEAT_BITS)

`endif

//--- src/frameTrigPkg.sv
// shared types for the frame trigger; widths follow frameTrig_config.svh
`include "frameTrig_config.svh"

package frameTrigPkg;

  //////////////////////////////////////////////////
  // stream types
  //////////////////////////////////////////////////

  // one beat of frame data
  typedef logic [`FT_BEAT_BITS-1:0] beatWord_t;

  // beat position within a frame
  // saturates at `FT_PATTERN_WORDS, meaning past the pattern
  typedef logic [2:0] beatIndex_t;

  //////////////////////////////////////////////////
  // matcher FSM
  //////////////////////////////////////////////////

  // idle      waiting for beat 0 of a frame
  // compare   pattern words matched so far
  // mismatch  frame failed, wait for its last beat
  // matched   pulse fired, wait for the last beat
  typedef enum logic [1:0] {
    MATCH_IDLE,
    MATCH_COMPARE,
    MATCH_MISMATCH,
    MATCH_MATCHED
  } matchState_t;

endpackage

//--- src/frameBeatCounter.sv
// counts accepted beats per frame; the count is only valid once a last beat has been seen
`include "frameTrig_config.svh"

module frameBeatCounter import frameTrigPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       beatValid,
  input  logic       beatLast,
  output beatIndex_t beatIndex
);

  //////////////////////////////////////////////////
  // saturation point
  //////////////////////////////////////////////////

  // anything at or beyond this index is outside the pattern
  localparam beatIndex_t PAST_PATTERN = beatIndex_t'(`FT_PATTERN_WORDS);

  logic atLimit;

  // long frames park here and never wrap back into the pattern range
  assign atLimit = (beatIndex == PAST_PATTERN);

  //////////////////////////////////////////////////
  // beat position
  //////////////////////////////////////////////////

  // beatIndex is the position of the beat now on the inputs
  // it moves on the same edge that accepts the beat
  always_ff @(posedge clk) begin
    if (reset) begin
      beatIndex <= '0;
    end else if (beatValid) begin
      if (beatLast) begin
        // next accepted beat opens a new frame
        beatIndex <= '0;
      end else if (!atLimit) begin
        beatIndex <= beatIndex + 3'd1;
      end
    end
  end

  // idle cycles with beatValid low leave the count alone

endmodule

//--- src/frameMatcher.sv
// compares the first `FT_PATTERN_WORDS beats of each frame; the stream must start on a frame boundary after reset
`include "frameTrig_config.svh"

module frameMatcher import frameTrigPkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`FT_PATTERN_BITS-1:0] compareString,
  input  beatWord_t                   beatData,
  input  logic [`FT_BEAT_BYTES-1:0]   beatStrobe,
  input  logic                        beatValid,
  input  logic                        beatLast,
  input  beatIndex_t                  beatIndex,
  output logic                        matchPulse
);

  // position of the final pattern beat
  localparam beatIndex_t FINAL_INDEX = beatIndex_t'(`FT_PATTERN_WORDS - 1);

  //////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////

  beatWord_t                 regData;
  logic [`FT_BEAT_BYTES-1:0] regStrobe;
  beatIndex_t                regIndex;
  logic                      regLast;
  logic                      regValid;

  // payload only loads on an accepted beat
  always_ff @(posedge clk) begin
    if (beatValid) begin
      regData   <= beatData;
      regStrobe <= beatStrobe;
      regIndex  <= beatIndex;
    end
  end

  // last flag holds across gaps, so matched/mismatch can still see it
  // regValid marks the single cycle a fresh beat sits in the register
  always_ff @(posedge clk) begin
    if (reset) begin
      regLast  <= 1'b0;
      regValid <= 1'b0;
    end else begin
      regValid <= beatValid;
      if (beatValid) begin
        regLast <= beatLast;
      end
    end
  end

  //////////////////////////////////////////////////
  // word compare
  //////////////////////////////////////////////////

  beatWord_t patternWord;
  logic      wordOk;

  // pick pattern word by registered index
  // indices past the pattern select zero and are never used
  always_comb begin
    patternWord = '0;
    for (int i = 0; i < `FT_PATTERN_WORDS; i++) begin
      if (regIndex == beatIndex_t'(i)) begin
        patternWord = compareString[i*`FT_BEAT_BITS +: `FT_BEAT_BITS];
      end
    end
  end

  // a partial strobe never counts as equal
  assign wordOk = (regData == patternWord) && (&regStrobe);

  //////////////////////////////////////////////////
  // match FSM
  //////////////////////////////////////////////////

  matchState_t state;
  matchState_t stateNext;

  always_comb begin
    stateNext = state;
    if (regValid && (regIndex == '0)) begin
      // beat 0 starts a fresh compare from any state
      if (regLast) begin
        stateNext = MATCH_IDLE;
      end else if (wordOk) begin
        stateNext = MATCH_COMPARE;
      end else begin
        stateNext = MATCH_MISMATCH;
      end
    end else begin
      case (state)
        MATCH_COMPARE: begin
          if (regValid) begin
            if (!wordOk) begin
              stateNext = regLast ? MATCH_IDLE : MATCH_MISMATCH;
            end else if (regIndex == FINAL_INDEX) begin
              // taken even on a last beat so a 5-beat frame still fires
              stateNext = MATCH_MATCHED;
            end else if (regLast) begin
              // frame ended before the pattern was complete
              stateNext = MATCH_IDLE;
            end
          end
        end
        MATCH_MISMATCH, MATCH_MATCHED: begin
          // regLast stays set after the final beat, gaps or not
          if (regLast) begin
            stateNext = MATCH_IDLE;
          end
        end
        default: begin
          // idle ignores mid-frame beats seen after reset
          stateNext = state;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= MATCH_IDLE;
      matchPulse <= 1'b0;
    end else begin
      state      <= stateNext;
      // one cycle, on entry into matched only
      matchPulse <= (stateNext == MATCH_MATCHED) && (state != MATCH_MATCHED);
    end
  end

endmodule

//--- src/triggerStretcher.sv
// holds the trigger for `FT_HOLD_CYCLES cycles after the last match pulse; a new pulse restarts the hold
`include "frameTrig_config.svh"

module triggerStretcher (
  input  logic clk,
  input  logic reset,
  input  logic matchPulse,
  output logic ilaTrigger
);

  //////////////////////////////////////////////////
  // hold counter
  //////////////////////////////////////////////////

  // wide enough to hold the full count
  localparam int COUNT_BITS = $clog2(`FT_HOLD_CYCLES + 1);

  localparam logic [COUNT_BITS-1:0] HOLD_LOAD = COUNT_BITS'(`FT_HOLD_CYCLES);

  logic [COUNT_BITS-1:0] holdCount;
  logic [COUNT_BITS-1:0] holdNext;

  // load on every pulse, reload while already high
  // otherwise count down and stop at zero
  always_comb begin
    if (matchPulse) begin
      holdNext = HOLD_LOAD;
    end else if (holdCount != '0) begin
      holdNext = holdCount - COUNT_BITS'(1);
    end else begin
      holdNext = '0;
    end
  end

  //////////////////////////////////////////////////
  // trigger register
  //////////////////////////////////////////////////

  // trigger follows the new count on the same edge
  // so it rises on the edge after the pulse, not one later
  always_ff @(posedge clk) begin
    if (reset) begin
      holdCount  <= '0;
      ilaTrigger <= 1'b0;
    end else begin
      holdCount  <= holdNext;
      ilaTrigger <= (holdNext != '0);
    end
  end

  // counts HOLD down to 1 give exactly `FT_HOLD_CYCLES high cycles

endmodule

//--- src/frameTriggerTop.sv
// trigger for a logic analyzer; stream has no back-pressure and the pattern is fixed per build
`include "frameTrig_config.svh"

module frameTriggerTop import frameTrigPkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`FT_PATTERN_BITS-1:0] compareString,
  input  beatWord_t                   beatData,
  input  logic [`FT_BEAT_BYTES-1:0]   beatStrobe,
  input  logic                        beatValid,
  input  logic                        beatLast,
  output logic                        ilaTrigger
);

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  // position of the beat on the inputs
  beatIndex_t beatIndex;

  // one cycle per matching frame
  logic matchPulse;

  //////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////

  // accept edge -> counter advances
  frameBeatCounter beatCounter (
    .clk       (clk),
    .reset     (reset),
    .beatValid (beatValid),
    .beatLast  (beatLast),
    .beatIndex (beatIndex)
  );

  // +1 edge register, +2 edge pulse
  frameMatcher matcher (
    .clk           (clk),
    .reset         (reset),
    .compareString (compareString),
    .beatData      (beatData),
    .beatStrobe    (beatStrobe),
    .beatValid     (beatValid),
    .beatLast      (beatLast),
    .beatIndex     (beatIndex),
    .matchPulse    (matchPulse)
  );

  // trigger rises 2 edges after the final pattern beat
  triggerStretcher stretcher (
    .clk        (clk),
    .reset      (reset),
    .matchPulse (matchPulse),
    .ilaTrigger (ilaTrigger)
  );

endmodule

//--- sim/frameTriggerChecker.sv
// reference model of match rule and hold time; needs reset held across at least one clock edge
`include "frameTrig_config.svh"

module frameTriggerChecker import frameTrigPkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`FT_PATTERN_BITS-1:0] compareString,
  input  beatWord_t                   beatData,
  input  logic [`FT_BEAT_BYTES-1:0]   beatStrobe,
  input  logic                        beatValid,
  input  logic                        beatLast,
  input  logic                        ilaTrigger,
  input  int                          timeoutCount,
  input  logic                        reportNow,
  output int                          errorCount
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////
  // model state
  //////////////////////////////////////////////////

  // position of the next accepted beat, parks at the pattern length
  int   beatCount = 0;
  logic frameGood = 1'b0;
  // accept edge -> stage1, next edge -> stage2, then the hold loads
  logic pulseStage1 = 1'b0;
  logic pulseStage2 = 1'b0;
  int   holdLeft = 0;
  logic expTrigger = 1'b0;
  logic seenEdge = 1'b0;
  int   cyclesChecked = 0;
  int   triggerCount = 0;
  int   valueErrors = 0;

  assign errorCount = valueErrors;

  // inputs read here are the values the DUT samples on the same edge
  always @(posedge clk) begin
    logic wordEqual;
    logic matchNow;
    wordEqual = 1'b0;
    matchNow  = 1'b0;
    seenEdge  = 1'b1;
    if (reset) begin
      beatCount   = 0;
      frameGood   = 1'b0;
      pulseStage1 = 1'b0;
      pulseStage2 = 1'b0;
      holdLeft    = 0;
      expTrigger  = 1'b0;
    end else begin
      if (beatValid) begin
        if (beatCount < `FT_PATTERN_WORDS) begin
          // word i sits at bits 32i and up, strobe must be full
          wordEqual = (beatData == beatWord_t'(compareString >> (beatCount * `FT_BEAT_BITS)))
                      && (&beatStrobe);
          frameGood = (beatCount == 0) ? wordEqual : (frameGood && wordEqual);
          // the final pattern beat may also be the last beat
          matchNow  = frameGood && (beatCount == `FT_PATTERN_WORDS - 1);
        end
        if (beatLast) begin
          beatCount = 0;
        end else if (beatCount < `FT_PATTERN_WORDS) begin
          beatCount++;
        end
      end
      // reload on every match, even while already high
      if (pulseStage2) begin
        holdLeft = `FT_HOLD_CYCLES;
      end else if (holdLeft > 0) begin
        holdLeft--;
      end
      if ((holdLeft != 0) && !expTrigger) begin
        triggerCount++;
      end
      expTrigger  = (holdLeft != 0);
      pulseStage2 = pulseStage1;
      pulseStage1 = matchNow;
    end
  end

  //////////////////////////////////////////////////
  // compare and report
  //////////////////////////////////////////////////

  // trigger is settled at the falling edge
  always @(negedge clk) begin
    if (seenEdge) begin
      cyclesChecked++;
      if (ilaTrigger !== expTrigger) begin
        valueErrors++;
        $display("[FAIL] ilaTrigger expected %h actual %h at %0t",
                 expTrigger, ilaTrigger, $time);
      end
    end
  end

  always @(posedge reportNow) begin
    $display("summary: %0d cycles checked, %0d trigger rises, %0d value errors, %0d timeouts",
             cyclesChecked, triggerCount, valueErrors, timeoutCount);
  end

endmodule

//--- sim/frameTriggerTb.sv
// frames come from a fixed table; filler words use seed 90, stuck waits give up after fixed limits
`include "frameTrig_config.svh"

module frameTriggerTb import frameTrigPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FRAMES  = 23;
  localparam int NONE        = -1;
  localparam int TABLE_LIMIT = 3000;
  localparam int QUIET_LIMIT = 200;

  // one frame: length, corrupted beat, partial-strobe beat, gaps, idle cycles after
  typedef struct packed {
    int len;
    int badIdx;
    int strobeIdx;
    bit gaps;
    int spacing;
  } frameEntry_t;

  logic                        clk = 1'b0;
  logic                        reset;
  logic [`FT_PATTERN_BITS-1:0] compareString;
  beatWord_t                   beatData;
  logic [`FT_BEAT_BYTES-1:0]   beatStrobe;
  logic                        beatValid;
  logic                        beatLast;
  logic                        ilaTrigger;

  frameEntry_t frameTable [NUM_FRAMES];
  int          seed = 90;
  logic        tableDone = 1'b0;
  logic        reportNow = 1'b0;
  int          timeoutCount = 0;
  int          errorCount;

  always #50 clk = ~clk;

  frameTriggerTop dut (
    .clk           (clk),
    .reset         (reset),
    .compareString (compareString),
    .beatData      (beatData),
    .beatStrobe    (beatStrobe),
    .beatValid     (beatValid),
    .beatLast      (beatLast),
    .ilaTrigger    (ilaTrigger)
  );

  frameTriggerChecker trigCheck (
    .clk           (clk),
    .reset         (reset),
    .compareString (compareString),
    .beatData      (beatData),
    .beatStrobe    (beatStrobe),
    .beatValid     (beatValid),
    .beatLast      (beatLast),
    .ilaTrigger    (ilaTrigger),
    .timeoutCount  (timeoutCount),
    .reportNow     (reportNow),
    .errorCount    (errorCount)
  );

  //////////////////////////////////////////////////
  // frame table
  //////////////////////////////////////////////////

  task automatic fillTable();
    frameTable[0]  = '{5, NONE, NONE, 1'b0, 15};   // exact match, 5 beats
    frameTable[1]  = '{20, NONE, NONE, 1'b0, 15};  // exact match, long frame
    frameTable[2]  = '{8, 0, NONE, 1'b0, 4};       // corrupted pattern words
    frameTable[3]  = '{8, 1, NONE, 1'b0, 4};
    frameTable[4]  = '{8, 2, NONE, 1'b0, 4};
    frameTable[5]  = '{8, 3, NONE, 1'b0, 4};
    frameTable[6]  = '{5, 4, NONE, 1'b0, 4};
    frameTable[7]  = '{8, 5, NONE, 1'b0, 15};      // corruption past the pattern
    frameTable[8]  = '{20, 12, NONE, 1'b0, 15};
    frameTable[9]  = '{3, NONE, NONE, 1'b0, 0};    // short, then match right after
    frameTable[10] = '{5, NONE, NONE, 1'b0, 15};
    frameTable[11] = '{1, NONE, NONE, 1'b0, 2};
    frameTable[12] = '{4, NONE, NONE, 1'b0, 0};
    frameTable[13] = '{6, NONE, NONE, 1'b0, 15};
    frameTable[14] = '{6, NONE, 0, 1'b0, 4};       // partial strobes
    frameTable[15] = '{6, NONE, 1, 1'b0, 4};
    frameTable[16] = '{6, NONE, 2, 1'b0, 4};
    frameTable[17] = '{6, NONE, 3, 1'b0, 4};
    frameTable[18] = '{5, NONE, 4, 1'b0, 4};
    frameTable[19] = '{7, NONE, NONE, 1'b1, 15};   // gaps inside the frame
    frameTable[20] = '{5, NONE, NONE, 1'b1, 15};
    frameTable[21] = '{5, NONE, NONE, 1'b0, 0};    // back to back, retrigger
    frameTable[22] = '{5, NONE, NONE, 1'b0, 20};
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  function automatic beatWord_t patternWord(input int idx);
    return beatWord_t'(compareString >> (idx * `FT_BEAT_BITS));
  endfunction

  // valid low, junk data on the bus
  task automatic idleCycles(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      beatData   <= $random(seed);
      beatStrobe <= '0;
      beatValid  <= 1'b0;
      beatLast   <= 1'b0;
    end
  endtask

  task automatic putBeat(input beatWord_t data, input logic [`FT_BEAT_BYTES-1:0] strobe,
                         input logic last);
    @(posedge clk);
    beatData   <= data;
    beatStrobe <= strobe;
    beatValid  <= 1'b1;
    beatLast   <= last;
  endtask

  task automatic sendFrame(input frameEntry_t entry);
    beatWord_t                 data;
    logic [`FT_BEAT_BYTES-1:0] strobe;
    logic                      last;
    int                        gapLen;
    for (int b = 0; b < entry.len; b++) begin
      last   = (b == entry.len - 1);
      strobe = '1;
      if (b < `FT_PATTERN_WORDS) begin
        data = patternWord(b);
      end else begin
        data = $random(seed);
        // a short tail strobe past the pattern must not matter
        if (last) begin
          strobe = 4'b0011;
        end
      end
      if (b == entry.badIdx) begin
        data = data ^ 32'h0000_0100;
      end
      if (b == entry.strobeIdx) begin
        strobe = 4'b0111;
      end
      putBeat(data, strobe, last);
      if (entry.gaps && !last) begin
        gapLen = $unsigned($random(seed)) % 3;
        idleCycles(gapLen + 1);
      end
    end
  endtask

  initial begin : stimulus
    reset      = 1'b1;
    beatData   = '0;
    beatStrobe = '0;
    beatValid  = 1'b0;
    beatLast   = 1'b0;
    // dest MAC 02:00:5e:10:00:01, source MAC 02:0a:0b:0c:0d:0e, type 88b5, tag cafe0042
    compareString = {32'h0042_0017, 32'h88B5_CAFE, 32'h0B0C_0D0E,
                     32'h0001_020A, 32'h0200_5E10};
    fillTable();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      sendFrame(frameTable[f]);
      idleCycles(frameTable[f].spacing);
    end
    tableDone = 1'b1;
  end

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  // trigger must stay low for longer than one hold window
  task automatic waitTriggerQuiet();
    int quietCycles;
    int waited;
    quietCycles = 0;
    waited      = 0;
    while (quietCycles < `FT_HOLD_CYCLES + 3 && waited < QUIET_LIMIT) begin
      @(negedge clk);
      waited++;
      quietCycles = ilaTrigger ? 0 : quietCycles + 1;
    end
    if (quietCycles < `FT_HOLD_CYCLES + 3) begin
      $display("timeout: ilaTrigger did not stay low within %0d cycles", QUIET_LIMIT);
      timeoutCount++;
    end
  endtask

  initial begin : supervisor
    int waited;
    waited = 0;
    while (!tableDone && waited < TABLE_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!tableDone) begin
      $display("timeout: frame table not finished after %0d cycles", TABLE_LIMIT);
      timeoutCount++;
    end else begin
      waitTriggerQuiet();
    end
    reportNow = 1'b1;
    #1;
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+src
src/frameTrigPkg.sv
src/frameBeatCounter.sv
src/frameMatcher.sv
src/triggerStretcher.sv
src/frameTriggerTop.sv
sim/frameTriggerChecker.sv
sim/frameTriggerTb.sv

//--- Makefile
# Verilator build and run for the frame trigger testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= frameTriggerTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS

SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# log is produced by running the simulator binary
$(LOG): $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true

# always reruns the simulation, fails unless the pass line is in the log
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

# judges the existing log, running the simulation first if needed
check: $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
